// File: vlog.f
+incdir+hw
hw/simon_pkg.sv
hw/sequence_memory.sv
hw/tone_generator.sv
hw/game_controller.sv
hw/simon_top.sv
bench/clock_gen.sv
bench/simon_tb.sv

// File: run_sim.sh
#!/bin/sh
# compiles the memory game bench with Verilator, runs it and looks for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ps --top-module simon_tb -Mdir obj_dir -f vlog.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vsimon_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx 'RESULT: PASS'; then
    exit 0
fi
echo "pass line not found in the simulation output"
exit 1

// File: bench/simon_tb.sv
// testbench for the memory game, plays seeded random games against a sequence model
`default_nettype none
`include "simon_settings.svh"

module simon_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int KEY_LIMIT  = `SIMON_COUNT_KEY;
    localparam int WAIT_LIMIT = 200;        // cycles allowed for any LED change

    logic       clock;
    logic       reset;
    logic       start;
    logic [3:0] keys;
    wire  [3:0] nl;
    wire        nloss;
    wire        speaker;

    integer     seed;
    int         mismatches;
    int         timeouts;
    logic       stalled;                    // a wait ran out, later waits return at once
    logic       quiet;                      // speaker must rest while the LEDs are dark
    logic [1:0] model [0:`SIMON_SEQ_DEPTH-1];

    int         cyc;
    int         edge_cyc;
    logic       edge_valid;
    logic       last_spk;
    logic [3:0] last_nl;
    logic       win_rise;                   // speaker rose during a lit win blink

    clock_gen clock_gen0 (
        .clock (clock),
        .reset (reset)
    );

    simon_top dut0 (
        .clock   (clock),
        .reset   (reset),
        .start   (start),
        .keys    (keys),
        .nl      (nl),
        .nloss   (nloss),
        .speaker (speaker)
    );

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (!stalled && got !== want) begin
            $display("[FAIL] %s got %h expected %h", name, got, want);
            mismatches++;
        end
    endtask

    task automatic stall(input string what);
        if (!stalled) begin
            $display("timeout: %s", what);
            timeouts++;
            stalled = 1'b1;
        end
    endtask

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        rand_below = int'(r % 32'(n));
    endfunction

    function automatic logic [3:0] led_of(input logic [1:0] color);
        led_of = 4'b0001 << color;
    endfunction

    function automatic logic [1:0] color_of(input logic [3:0] led);
        color_of = 2'd0;
        for (int b = 3; b >= 0; b--) begin
            if (led[b]) color_of = 2'(b);
        end
    endfunction

    // timebase of round n, one tick shorter per completed round
    function automatic int note_time(input int n);
        note_time = `SIMON_COUNT_SEQ - n + 1;
    endfunction

    function automatic int half_period(input logic [3:0] led);
        case (led)
            4'b0001: half_period = `SIMON_TONE_RED + 2;
            4'b0010: half_period = `SIMON_TONE_GREEN + 2;
            4'b0100: half_period = `SIMON_TONE_YELLOW + 2;
            4'b1000: half_period = `SIMON_TONE_BLUE + 2;
            default: half_period = 0;
        endcase
    endfunction

    // waits for the next lit LED, then counts the cycles it stays
    task automatic next_pulse(output logic [3:0] led, output int cycles);
        int n;
        led = 4'b0000;
        cycles = 0;
        n = 0;
        while (nl == 4'b0000 && n < WAIT_LIMIT && !stalled) begin
            @(negedge clock);
            n++;
        end
        if (nl == 4'b0000) begin
            stall("no LED lit while waiting for the next note");
        end else begin
            led = nl;
            while (nl == led && cycles < WAIT_LIMIT && !stalled) begin
                @(negedge clock);
                cycles++;
            end
            if (nl == led) stall("an LED stayed lit far too long");
        end
    endtask

    task automatic start_game();
        quiet = 1'b0;
        start = 1'b1;                       // one-cycle pulse
        @(negedge clock);
        start = 1'b0;
        repeat (3) @(negedge clock);
        check_value("nloss", 32'(nloss), 32'd0);
        check_value("nl", 32'(nl), 32'd0);
        quiet = 1'b1;
    endtask

    // round n shows n notes, the last one is the new colour
    task automatic check_playback(input int n);
        logic [3:0] led;
        int cycles;
        for (int i = 0; i < n; i++) begin
            next_pulse(led, cycles);
            if (i < n - 1) begin
                check_value("nl", 32'(led), 32'(led_of(model[i])));
            end else begin
                check_value("nl one-hot", 32'($onehot(led)), 32'd1);
                model[i] = color_of(led);
            end
            check_value("note width", 32'(cycles), 32'(note_time(n) + 1));
            check_value("nloss", 32'(nloss), 32'd0);
        end
    endtask

    task automatic press_key(input logic [3:0] key, output logic [3:0] led, output int cycles);
        repeat (rand_below(16)) @(negedge clock);
        keys = key;
        next_pulse(led, cycles);            // held through the echo
        keys = 4'b0000;
    endtask

    task automatic enter_keys(input int n, input int count);
        logic [3:0] led;
        int cycles;
        for (int j = 0; j < count; j++) begin
            press_key(led_of(model[j]), led, cycles);
            check_value("nl", 32'(led), 32'(led_of(model[j])));
            check_value("echo width", 32'(cycles), 32'(note_time(n) + 1));
            check_value("nloss", 32'(nloss), 32'd0);
        end
    endtask

    // replay up to the failed step, then the failed colour blinks
    task automatic check_loss_display(input int step, input int note);
        logic [3:0] led;
        int cycles;
        for (int i = 0; i <= step; i++) begin
            next_pulse(led, cycles);
            check_value("nl", 32'(led), 32'(led_of(model[i])));
            check_value("replay width", 32'(cycles), 32'(note + 1));
            check_value("nloss", 32'(nloss), 32'd1);
        end
        for (int k = 0; k < 3; k++) begin
            next_pulse(led, cycles);
            check_value("nl", 32'(led), 32'(led_of(model[step])));
            check_value("loss blink width", 32'(cycles), 32'(`SIMON_COUNT_FIN + 1));
            check_value("nloss", 32'(nloss), 32'd1);
        end
    endtask

    // speaker half period while one colour LED is lit, silence while dark,
    // win tone while all LEDs are lit
    always @(negedge clock) begin
        if (reset) begin
            cyc = 0;
            edge_cyc = 0;
            edge_valid = 1'b0;
            last_spk = 1'b0;
            last_nl = 4'b0000;
            win_rise = 1'b0;
        end else begin
            cyc = cyc + 1;
            if (nl != last_nl || nloss) edge_valid = 1'b0;    // new note or loss tones
            if (speaker != last_spk && $onehot(nl) && !nloss) begin
                if (edge_valid) begin
                    check_value("speaker half period", 32'(cyc - edge_cyc),
                                32'(half_period(nl)));
                end
                edge_valid = 1'b1;
                edge_cyc = cyc;
            end
            if (nl != last_nl) begin
                if (last_nl == 4'b1111) begin
                    check_value("speaker rise in win blink", 32'(win_rise), 32'd1);
                end
                win_rise = 1'b0;
            end
            if (speaker && !last_spk && nl == 4'b1111) win_rise = 1'b1;
            if (quiet && !nloss && nl == 4'b0000 && last_nl == 4'b0000) begin
                check_value("speaker", 32'(speaker), 32'd0);
            end
            last_spk = speaker;
            last_nl = nl;
        end
    end

    initial begin
        logic [3:0] led;
        int cycles;
        int fail_round;
        int fail_step;
        int waited;
        logic [1:0] wrong;
        seed = 32'h9933adca;
        start = 1'b0;
        keys = 4'b0000;
        mismatches = 0;
        timeouts = 0;
        stalled = 1'b0;
        quiet = 1'b0;

        @(posedge clock);
        for (int i = 0; i < 100; i++) begin      // idle through and after reset
            @(negedge clock);
            check_value("nl", 32'(nl), 32'd0);
            check_value("nloss", 32'(nloss), 32'd0);
            check_value("speaker", 32'(speaker), 32'd0);
        end

        start_game();                           // a full game to the win
        for (int n = 1; n <= `SIMON_SEQ_DEPTH; n++) begin
            check_playback(n);
            enter_keys(n, n);
        end
        quiet = 1'b0;
        for (int k = 0; k < 4; k++) begin
            next_pulse(led, cycles);
            check_value("nl", 32'(led), 32'hf);
            check_value("win blink width", 32'(cycles), 32'(`SIMON_COUNT_FIN + 1));
            check_value("nloss", 32'(nloss), 32'd0);
        end

        start_game();                           // wrong key in a random round
        fail_round = 2 + rand_below(5);
        for (int n = 1; n < fail_round; n++) begin
            check_playback(n);
            enter_keys(n, n);
        end
        check_playback(fail_round);
        fail_step = rand_below(fail_round);
        enter_keys(fail_round, fail_step);
        wrong = model[fail_step] + 2'(rand_below(3) + 1);
        press_key(led_of(wrong), led, cycles);
        check_value("nl", 32'(led), 32'(led_of(wrong)));
        check_value("error echo width", 32'(cycles), 32'(note_time(fail_round) + 1));
        check_value("nloss", 32'(nloss), 32'd1);
        check_loss_display(fail_step, note_time(fail_round));

        start_game();                           // no key at all
        check_playback(1);
        waited = 0;
        while (!nloss && waited < note_time(1) + 1 + KEY_LIMIT + 4 && !stalled) begin
            @(negedge clock);
            waited++;
        end
        if (!nloss) stall("nloss did not rise after an unanswered key wait");
        check_value("nloss before key wait end", 32'(waited <= note_time(1) + KEY_LIMIT),
                    32'd0);
        check_loss_display(0, note_time(1));

        $display("mismatches: %0d, timeouts: %0d", mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/clock_gen.sv
// clock and power-up reset source for the memory game testbench
`default_nettype none

module clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 4
) (
    output logic clock,
    output logic reset
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;                       // released on a falling edge like the other inputs
    end

endmodule

`default_nettype wire

// File: hw/simon_top.sv
// memory game top, ties the FSM to the sequence store and the speaker driver at the game pins
`default_nettype none

module simon_top (
    input  wire        clock,
    input  wire        reset,
    input  wire        start,
    input  wire [3:0]  keys,
    output wire [3:0]  nl,
    output wire        nloss,
    output wire        speaker
);

    simon_pkg::seq_mem_req_t mem_req;
    simon_pkg::color_t       rdata;
    simon_pkg::tone_cmd_t    tone;

    game_controller u_game_controller (
        .clock   (clock),
        .reset   (reset),
        .start   (start),
        .keys    (keys),
        .rdata   (rdata),
        .mem_req (mem_req),
        .tone    (tone),
        .nl      (nl),
        .nloss   (nloss)
    );

    sequence_memory u_sequence_memory (
        .clock (clock),
        .req   (mem_req),
        .rdata (rdata)
    );

    tone_generator u_tone_generator (
        .clock   (clock),
        .reset   (reset),
        .cmd     (tone),
        .speaker (speaker)
    );

endmodule

`default_nettype wire

// File: hw/game_controller.sv
// memory game FSM: grows the colour sequence, plays it back, checks the keys, shows loss and win
`default_nettype none
`include "simon_settings.svh"

module game_controller (
    input  wire                       clock,
    input  wire                       reset,
    input  wire                       start,
    input  wire [3:0]                 keys,
    input  wire simon_pkg::color_t    rdata,
    output simon_pkg::seq_mem_req_t   mem_req,
    output simon_pkg::tone_cmd_t      tone,
    output logic [3:0]                nl,
    output logic                      nloss
);

    localparam simon_pkg::seq_addr_t LAST_STEP = simon_pkg::seq_addr_t'(`SIMON_SEQ_DEPTH - 1);

    simon_pkg::game_state_t state;
    simon_pkg::color_t      num;        // free-running colour source
    simon_pkg::color_t      ind;        // colour of the last key
    simon_pkg::color_t      key_color;
    simon_pkg::seq_addr_t   scan;       // step being played or checked
    simon_pkg::seq_addr_t   max;        // last step of the round, replay index after a loss
    simon_pkg::tick_t       timebase;   // note time of this round
    simon_pkg::tick_t       count;

    function automatic logic [3:0] led_for(input simon_pkg::color_t color);
        led_for = 4'b0001 << color;
    endfunction

    // lowest key index wins
    always_comb begin
        if (keys[0]) begin
            key_color = 2'd0;
        end else if (keys[1]) begin
            key_color = 2'd1;
        end else if (keys[2]) begin
            key_color = 2'd2;
        end else begin
            key_color = 2'd3;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            num <= '0;
        end else begin
            num <= num + 2'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= simon_pkg::ST_IDLE;
            nl       <= '0;
            nloss    <= 1'b0;
            tone     <= '0;
            mem_req  <= '0;
            ind      <= '0;
            scan     <= '0;
            max      <= '0;
            timebase <= '0;
            count    <= '0;
        end else if (start) begin
            state <= simon_pkg::ST_NEW_GAME;        // restart from anywhere
        end else begin
            case (state)
                simon_pkg::ST_IDLE: begin
                    state <= simon_pkg::ST_IDLE;
                end
                simon_pkg::ST_NEW_GAME: begin
                    nl         <= '0;
                    nloss      <= 1'b0;
                    tone.play  <= 1'b0;
                    mem_req.we <= 1'b0;
                    max        <= '0;
                    timebase   <= simon_pkg::tick_t'(`SIMON_COUNT_SEQ);
                    state      <= simon_pkg::ST_ROUND;
                end
                simon_pkg::ST_ROUND: begin
                    scan    <= '0;
                    mem_req <= '{we: 1'b1, addr: max, wdata: num};   // append a colour
                    state   <= simon_pkg::ST_PLAY_ADDR;
                end
                simon_pkg::ST_PLAY_ADDR: begin
                    mem_req.we   <= 1'b0;
                    mem_req.addr <= scan;
                    state        <= simon_pkg::ST_PLAY_WAIT;
                end
                simon_pkg::ST_PLAY_WAIT: begin
                    state <= simon_pkg::ST_PLAY_SHOW;       // read latency
                end
                simon_pkg::ST_PLAY_SHOW: begin
                    nl    <= led_for(rdata);
                    tone  <= '{play: 1'b1, sound: {1'b0, rdata}};
                    count <= timebase;
                    state <= simon_pkg::ST_PLAY_ON;
                end
                simon_pkg::ST_PLAY_ON: begin
                    if (count == '0) begin
                        nl        <= '0;
                        tone.play <= 1'b0;
                        count     <= timebase;
                        state     <= simon_pkg::ST_PLAY_OFF;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                simon_pkg::ST_PLAY_OFF: begin
                    if (count == '0) begin
                        if (scan != max) begin
                            scan  <= scan + 1'b1;
                            state <= simon_pkg::ST_PLAY_ADDR;
                        end else begin
                            scan  <= '0;                    // player's turn
                            state <= simon_pkg::ST_KEY_ADDR;
                        end
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                simon_pkg::ST_KEY_ADDR: begin
                    count        <= simon_pkg::tick_t'(`SIMON_COUNT_KEY);
                    mem_req.addr <= scan;
                    state        <= simon_pkg::ST_KEY_WAIT;
                end
                simon_pkg::ST_KEY_WAIT: begin
                    state <= simon_pkg::ST_KEY_POLL;
                end
                simon_pkg::ST_KEY_POLL: begin
                    if (count == '0) begin
                        nloss <= 1'b1;                      // no key in time
                        max   <= '0;
                        state <= simon_pkg::ST_LOSS_ADDR;
                    end else begin
                        count <= count - 1'b1;
                        if (|keys) begin
                            ind   <= key_color;
                            tone  <= '{play: 1'b1, sound: {1'b0, key_color}};
                            count <= timebase;
                            if (key_color == rdata) begin
                                state <= simon_pkg::ST_KEY_ECHO;
                            end else begin
                                nloss <= 1'b1;
                                state <= simon_pkg::ST_ERR_ECHO;
                            end
                        end
                    end
                end
                simon_pkg::ST_KEY_ECHO: begin
                    nl    <= led_for(ind);
                    state <= simon_pkg::ST_KEY_ON;
                end
                simon_pkg::ST_KEY_ON: begin
                    if (count == '0) begin
                        nl        <= '0;
                        tone.play <= 1'b0;
                        count     <= timebase;
                        state     <= simon_pkg::ST_KEY_OFF;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                simon_pkg::ST_KEY_OFF: begin
                    if (count == '0) begin
                        if (scan != max) begin
                            scan  <= scan + 1'b1;
                            state <= simon_pkg::ST_KEY_ADDR;
                        end else if (max != LAST_STEP) begin
                            max      <= max + 1'b1;             // round done, one note more
                            timebase <= timebase - 1'b1;        // and a little faster
                            state    <= simon_pkg::ST_ROUND;
                        end else begin
                            nl    <= 4'b1111;                   // all leds with the win tone
                            tone  <= '{play: 1'b1, sound: simon_pkg::SOUND_WIN};
                            count <= simon_pkg::tick_t'(`SIMON_COUNT_FIN);
                            state <= simon_pkg::ST_WIN_ON;
                        end
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                simon_pkg::ST_ERR_ECHO: begin
                    nl    <= led_for(ind);                  // show the wrong key
                    state <= simon_pkg::ST_ERR_ON;
                end
                simon_pkg::ST_ERR_ON: begin
                    if (count == '0) begin
                        nl        <= '0;
                        tone.play <= 1'b0;
                        count     <= timebase;
                        state     <= simon_pkg::ST_ERR_OFF;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                simon_pkg::ST_ERR_OFF: begin
                    if (count == '0) begin
                        max   <= '0;
                        state <= simon_pkg::ST_LOSS_ADDR;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                simon_pkg::ST_LOSS_ADDR: begin
                    mem_req.addr <= max;                    // replay up to the failed step
                    state        <= simon_pkg::ST_LOSS_WAIT;
                end
                simon_pkg::ST_LOSS_WAIT: begin
                    state <= simon_pkg::ST_LOSS_SHOW;
                end
                simon_pkg::ST_LOSS_SHOW: begin
                    nl    <= led_for(rdata);
                    tone  <= '{play: 1'b1, sound: {1'b0, rdata}};
                    count <= timebase;
                    state <= simon_pkg::ST_LOSS_ON;
                end
                simon_pkg::ST_LOSS_ON: begin
                    if (count == '0) begin
                        nl        <= '0;
                        tone.play <= 1'b0;
                        count     <= timebase;
                        state     <= simon_pkg::ST_LOSS_OFF;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                simon_pkg::ST_LOSS_OFF: begin
                    if (count == '0) begin
                        if (max != scan) begin
                            max   <= max + 1'b1;
                            state <= simon_pkg::ST_LOSS_ADDR;
                        end else begin
                            nl    <= led_for(rdata);            // failed colour
                            tone  <= '{play: 1'b1, sound: simon_pkg::SOUND_LOSS};
                            count <= simon_pkg::tick_t'(`SIMON_COUNT_FIN);
                            state <= simon_pkg::ST_BLINK_ON;
                        end
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                simon_pkg::ST_BLINK_ON: begin
                    if (count == '0) begin
                        nl        <= '0;
                        tone.play <= 1'b0;
                        count     <= simon_pkg::tick_t'(`SIMON_COUNT_FIN);
                        state     <= simon_pkg::ST_BLINK_OFF;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                simon_pkg::ST_BLINK_OFF: begin
                    if (count == '0) begin
                        nl    <= led_for(rdata);                // address still on failed step
                        tone  <= '{play: 1'b1, sound: simon_pkg::SOUND_LOSS};
                        count <= simon_pkg::tick_t'(`SIMON_COUNT_FIN);
                        state <= simon_pkg::ST_BLINK_ON;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                simon_pkg::ST_WIN_ON: begin
                    if (count == '0) begin
                        nl        <= '0;                        // dark and silent
                        tone.play <= 1'b0;
                        count     <= simon_pkg::tick_t'(`SIMON_COUNT_FIN);
                        state     <= simon_pkg::ST_WIN_OFF;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                simon_pkg::ST_WIN_OFF: begin
                    if (count == '0) begin
                        nl    <= 4'b1111;                       // all leds, win tone
                        tone  <= '{play: 1'b1, sound: simon_pkg::SOUND_WIN};
                        count <= simon_pkg::tick_t'(`SIMON_COUNT_FIN);
                        state <= simon_pkg::ST_WIN_ON;
                    end else begin
                        count <= count - 1'b1;
                    end
                end
                default: begin
                    state <= simon_pkg::ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/tone_generator.sv
// square-wave speaker driver, one half period per sound code of the tone command
`default_nettype none
`include "simon_settings.svh"

module tone_generator (
    input  wire                  clock,
    input  wire                  reset,
    input  wire simon_pkg::tone_cmd_t cmd,
    output logic                 speaker
);

    logic [2:0] limit;      // counter value that ends a half period
    logic       audible;    // sound code has a tone
    logic [2:0] counter;

    always_comb begin
        audible = 1'b1;
        case (cmd.sound)
            simon_pkg::SOUND_RED: begin
                limit = 3'(`SIMON_TONE_RED);
            end
            simon_pkg::SOUND_GREEN: begin
                limit = 3'(`SIMON_TONE_GREEN);
            end
            simon_pkg::SOUND_YELLOW: begin
                limit = 3'(`SIMON_TONE_YELLOW);
            end
            simon_pkg::SOUND_BLUE: begin
                limit = 3'(`SIMON_TONE_BLUE);
            end
            simon_pkg::SOUND_WIN: begin
                limit = 3'(`SIMON_TONE_WIN);
            end
            simon_pkg::SOUND_LOSS: begin
                limit = 3'(`SIMON_TONE_LOSS);
            end
            default: begin
                limit   = '0;
                audible = 1'b0;             // codes 6 and 7
            end
        endcase
    end

    // counter runs 0 .. limit + 1, so one half period is limit + 2 cycles
    always_ff @(posedge clock) begin
        if (reset || !cmd.play || !audible) begin
            counter <= '0;
            speaker <= 1'b0;
        end else if (counter > limit) begin
            counter <= '0;
            speaker <= ~speaker;
        end else begin
            counter <= counter + 3'd1;
        end
    end

endmodule

`default_nettype wire

// File: hw/sequence_memory.sv
// single-port colour store for the game sequence, read data registered one cycle after the address
`default_nettype none
`include "simon_settings.svh"

module sequence_memory (
    input  wire                     clock,
    input  wire simon_pkg::seq_mem_req_t req,
    output simon_pkg::color_t       rdata
);

    // no reset on the contents, each step is written before playback reaches it
    simon_pkg::color_t mem [0:`SIMON_SEQ_DEPTH-1];

    always_ff @(posedge clock) begin
        rdata <= mem[req.addr];                 // old value on a write cycle
        if (req.we) begin
            mem[req.addr] <= req.wdata;
        end
    end

endmodule

`default_nettype wire

// File: hw/simon_pkg.sv
// shared types of the memory game, referenced by scoped name from the RTL and the bench
`default_nettype none
`include "simon_settings.svh"

package simon_pkg;

    typedef logic [1:0] color_t;                               // red 0, green 1, yellow 2, blue 3
    typedef logic [$clog2(`SIMON_SEQ_DEPTH)-1:0] seq_addr_t;   // sequence position
    typedef logic [5:0] tick_t;                                // note and pause counter
    typedef logic [2:0] sound_t;                               // colours, then win and loss

    localparam sound_t SOUND_RED    = 3'd0;
    localparam sound_t SOUND_GREEN  = 3'd1;
    localparam sound_t SOUND_YELLOW = 3'd2;
    localparam sound_t SOUND_BLUE   = 3'd3;
    localparam sound_t SOUND_WIN    = 3'd4;
    localparam sound_t SOUND_LOSS   = 3'd5;

    typedef enum logic [4:0] {
        ST_IDLE, ST_NEW_GAME, ST_ROUND,
        ST_PLAY_ADDR, ST_PLAY_WAIT, ST_PLAY_SHOW, ST_PLAY_ON, ST_PLAY_OFF,
        ST_KEY_ADDR, ST_KEY_WAIT, ST_KEY_POLL, ST_KEY_ECHO, ST_KEY_ON, ST_KEY_OFF,
        ST_ERR_ECHO, ST_ERR_ON, ST_ERR_OFF,
        ST_LOSS_ADDR, ST_LOSS_WAIT, ST_LOSS_SHOW, ST_LOSS_ON, ST_LOSS_OFF,
        ST_BLINK_ON, ST_BLINK_OFF,
        ST_WIN_ON, ST_WIN_OFF
    } game_state_t;

    typedef struct packed {
        logic      we;      // store wdata at addr
        seq_addr_t addr;
        color_t    wdata;
    } seq_mem_req_t;

    typedef struct packed {
        logic   play;       // speaker runs while high
        sound_t sound;
    } tone_cmd_t;

endpackage

`default_nettype wire

// File: hw/simon_settings.svh
// sequence depth, tick counts and tone limits for the memory game, included by the RTL and bench
`ifndef SIMON_SETTINGS_SVH
`define SIMON_SETTINGS_SVH

// sequence length that wins the game
`define SIMON_SEQ_DEPTH 32

// note time of the first round, in clock cycles (minus one)
`define SIMON_COUNT_SEQ 33

// polls allowed for each key press
`define SIMON_COUNT_KEY 33

// on and off time of the win and loss blinks
`define SIMON_COUNT_FIN 8

// tone limits, the speaker toggles every limit + 2 cycles
`define SIMON_TONE_RED    2
`define SIMON_TONE_GREEN  3
`define SIMON_TONE_YELLOW 4
`define SIMON_TONE_BLUE   5
`define SIMON_TONE_WIN    6
`define SIMON_TONE_LOSS   1

`endif
